//--- verilog/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Datapath and address width
`define DATA_W 32

// Register file geometry
`define REG_ADDR_W 5
`define NUM_REGS 32

// Shift amount field width
`define SHAMT_W 5

// Boot address and the address that stops the core
`define RESET_VECTOR 32'hBFC0_0000
`define HALT_ADDR 32'h0000_0000

// Register mirrored on register_v0
`define REG_V0 2

`endif

//--- verilog/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // Primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_REGIMM  = 6'b000001,
        OP_J       = 6'b000010,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_LW      = 6'b100011,
        OP_SW      = 6'b101011
    } opcode_t;

    // SPECIAL function codes, bits 5:0
    typedef enum logic [5:0] {
        F_SLL  = 6'b000000,
        F_SRL  = 6'b000010,
        F_SRA  = 6'b000011,
        F_SLLV = 6'b000100,
        F_SRLV = 6'b000110,
        F_SRAV = 6'b000111,
        F_JR   = 6'b001000,
        F_ADDU = 6'b100001,
        F_SUBU = 6'b100011,
        F_AND  = 6'b100100,
        F_OR   = 6'b100101,
        F_XOR  = 6'b100110,
        F_SLT  = 6'b101010,
        F_SLTU = 6'b101011
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BGTZ,
        BR_BLEZ,
        BR_BLTZ,
        BR_BGEZ,
        BR_JUMP,
        BR_JUMP_REG
    } branch_kind_t;

    typedef enum logic {
        RUNNING = 1'b0,
        HALTED  = 1'b1
    } run_state_t;

endpackage

`default_nettype wire

//--- verilog/alu.sv
`default_nettype none

`include "mips_config.svh"

module alu
    import mips_pkg::*;
(
    input  wire  alu_op_t                alu_op,
    input  wire  logic [`DATA_W-1:0]     a,
    input  wire  logic [`DATA_W-1:0]     b,
    input  wire  logic [`SHAMT_W-1:0]    shamt,
    output logic [`DATA_W-1:0]           result
);

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = {{(`DATA_W-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(`DATA_W-1){1'b0}}, lt_unsigned};
            // Shifts act on the rt operand
            ALU_SLL:  result = b << shamt;
            ALU_SRL:  result = b >> shamt;
            ALU_SRA:  result = $signed(b) >>> shamt;
            ALU_LUI:  result = {b[15:0], 16'b0};
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`default_nettype none

`include "mips_config.svh"

module reg_file (
    input  wire  logic                   clk,
    input  wire  logic                   reset,
    input  wire  logic [`REG_ADDR_W-1:0] rs_addr,
    input  wire  logic [`REG_ADDR_W-1:0] rt_addr,
    input  wire  logic [`REG_ADDR_W-1:0] wr_addr,
    input  wire  logic                   wr_en,
    input  wire  logic [`DATA_W-1:0]     wr_data,
    output logic [`DATA_W-1:0]           rs_data,
    output logic [`DATA_W-1:0]           rt_data,
    output logic [`DATA_W-1:0]           v0
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];
    assign v0 = regs[`REG_V0];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // r0 never leaves zero once out of reset
    zero_reg_held: assert property (
        @(posedge clk) disable iff (reset)
        regs[0] == '0
    );

endmodule

`default_nettype wire

//--- verilog/instr_decode.sv
`default_nettype none

`include "mips_config.svh"

module instr_decode
    import mips_pkg::*;
(
    input  wire  logic [`DATA_W-1:0] instr,
    input  wire  logic               step,
    output logic [`REG_ADDR_W-1:0]   rs_addr,
    output logic [`REG_ADDR_W-1:0]   rt_addr,
    output logic [`REG_ADDR_W-1:0]   wr_addr,
    output logic                     wr_en,
    output alu_op_t                  alu_op,
    output logic                     use_imm,
    output logic                     imm_signed,
    output logic [`SHAMT_W-1:0]      shamt,
    output logic                     shift_var,
    output logic [15:0]              imm16,
    output logic [25:0]              jump_index,
    output branch_kind_t             branch_kind,
    output logic                     mem_to_reg,
    output logic                     data_write,
    output logic                     data_read
);

    opcode_t                 opcode;
    funct_t                  funct;
    logic [`REG_ADDR_W-1:0]  rd_addr;
    logic                    wr_sel_rt;
    logic                    wr_req;
    logic                    store_req;

    assign opcode = opcode_t'(instr[31:26]);
    assign funct = funct_t'(instr[5:0]);
    assign rs_addr = instr[25:21];
    assign rt_addr = instr[20:16];
    assign rd_addr = instr[15:11];
    assign shamt = instr[10:6];
    assign imm16 = instr[15:0];
    assign jump_index = instr[25:0];

    always_comb begin
        alu_op = ALU_ADD;
        use_imm = 1'b0;
        imm_signed = 1'b0;
        shift_var = 1'b0;
        wr_sel_rt = 1'b0;
        wr_req = 1'b0;
        mem_to_reg = 1'b0;
        store_req = 1'b0;
        branch_kind = BR_NONE;
        case (opcode)
            OP_SPECIAL: begin
                wr_req = 1'b1;
                case (funct)
                    F_ADDU: alu_op = ALU_ADD;
                    F_SUBU: alu_op = ALU_SUB;
                    F_AND:  alu_op = ALU_AND;
                    F_OR:   alu_op = ALU_OR;
                    F_XOR:  alu_op = ALU_XOR;
                    F_SLT:  alu_op = ALU_SLT;
                    F_SLTU: alu_op = ALU_SLTU;
                    F_SLL:  alu_op = ALU_SLL;
                    F_SRL:  alu_op = ALU_SRL;
                    F_SRA:  alu_op = ALU_SRA;
                    F_SLLV: begin
                        alu_op = ALU_SLL;
                        shift_var = 1'b1;
                    end
                    F_SRLV: begin
                        alu_op = ALU_SRL;
                        shift_var = 1'b1;
                    end
                    F_SRAV: begin
                        alu_op = ALU_SRA;
                        shift_var = 1'b1;
                    end
                    F_JR: begin
                        wr_req = 1'b0;
                        branch_kind = BR_JUMP_REG;
                    end
                    default: wr_req = 1'b0;
                endcase
            end
            // rt selects the condition here
            OP_REGIMM: begin
                if (rt_addr == 5'b00000) begin
                    branch_kind = BR_BLTZ;
                end else if (rt_addr == 5'b00001) begin
                    branch_kind = BR_BGEZ;
                end
            end
            OP_J:    branch_kind = BR_JUMP;
            OP_BEQ:  branch_kind = BR_BEQ;
            OP_BNE:  branch_kind = BR_BNE;
            OP_BLEZ: branch_kind = BR_BLEZ;
            OP_BGTZ: branch_kind = BR_BGTZ;
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                use_imm = 1'b1;
                wr_sel_rt = 1'b1;
                wr_req = 1'b1;
                imm_signed = (opcode == OP_ADDIU) || (opcode == OP_SLTI)
                          || (opcode == OP_SLTIU);
                case (opcode)
                    OP_SLTI:  alu_op = ALU_SLT;
                    OP_SLTIU: alu_op = ALU_SLTU;
                    OP_ANDI:  alu_op = ALU_AND;
                    OP_ORI:   alu_op = ALU_OR;
                    OP_XORI:  alu_op = ALU_XOR;
                    OP_LUI:   alu_op = ALU_LUI;
                    default:  alu_op = ALU_ADD;
                endcase
            end
            OP_LW: begin
                use_imm = 1'b1;
                imm_signed = 1'b1;
                wr_sel_rt = 1'b1;
                wr_req = 1'b1;
                mem_to_reg = 1'b1;
            end
            OP_SW: begin
                use_imm = 1'b1;
                imm_signed = 1'b1;
                store_req = 1'b1;
            end
            default: branch_kind = BR_NONE;
        endcase
    end

    assign wr_addr = wr_sel_rt ? rt_addr : rd_addr;

    // No side effects outside an executing cycle
    assign wr_en = step && wr_req;
    assign data_write = step && store_req;
    assign data_read = step && mem_to_reg;

endmodule

`default_nettype wire

//--- verilog/pc_unit.sv
`default_nettype none

`include "mips_config.svh"

module pc_unit
    import mips_pkg::*;
(
    input  wire  logic               clk,
    input  wire  logic               reset,
    input  wire  logic               clk_enable,
    input  wire  branch_kind_t       branch_kind,
    input  wire  logic [15:0]        imm16,
    input  wire  logic [25:0]        jump_index,
    input  wire  logic [`DATA_W-1:0] rs_data,
    input  wire  logic [`DATA_W-1:0] rt_data,
    output logic [`DATA_W-1:0]       pc,
    output logic                     step,
    output logic                     active
);

    run_state_t          state;
    logic                redirect_pending;
    logic [`DATA_W-1:0]  redirect_target;
    logic [`DATA_W-1:0]  pc_plus4;
    logic [`DATA_W-1:0]  branch_target;
    logic [`DATA_W-1:0]  jump_target;
    logic [`DATA_W-1:0]  taken_target;
    logic                rs_zero;
    logic                rs_neg;
    logic                taken;

    assign pc_plus4 = pc + 4;
    assign branch_target = pc_plus4 + {{(`DATA_W-18){imm16[15]}}, imm16, 2'b00};
    assign jump_target = {pc_plus4[`DATA_W-1:`DATA_W-4], jump_index, 2'b00};

    assign rs_zero = (rs_data == '0);
    assign rs_neg = rs_data[`DATA_W-1];

    assign step = (state == RUNNING) && clk_enable && (pc != `HALT_ADDR);
    assign active = (state == RUNNING);

    always_comb begin
        taken = 1'b0;
        taken_target = branch_target;
        case (branch_kind)
            BR_BEQ:      taken = (rs_data == rt_data);
            BR_BNE:      taken = (rs_data != rt_data);
            BR_BGTZ:     taken = !rs_neg && !rs_zero;
            BR_BLEZ:     taken = rs_neg || rs_zero;
            BR_BLTZ:     taken = rs_neg;
            BR_BGEZ:     taken = !rs_neg;
            BR_JUMP: begin
                taken = 1'b1;
                taken_target = jump_target;
            end
            BR_JUMP_REG: begin
                taken = 1'b1;
                taken_target = rs_data;
            end
            default:     taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_VECTOR;
            redirect_pending <= 1'b0;
            state <= RUNNING;
        end else if (step) begin
            // Delay slot first, then the pending target
            pc <= redirect_pending ? redirect_target : pc_plus4;
            redirect_pending <= taken;
        end else if (state == RUNNING && clk_enable) begin
            state <= HALTED;
        end
    end

    always_ff @(posedge clk) begin
        if (step && taken) begin
            redirect_target <= taken_target;
        end
    end

    pc_aligned: assert property (
        @(posedge clk) disable iff (reset)
        (state == RUNNING) |-> (pc[1:0] == 2'b00)
    );

endmodule

`default_nettype wire

//--- verilog/mips_cpu_harvard.sv
`default_nettype none

`include "mips_config.svh"

module mips_cpu_harvard
    import mips_pkg::*;
(
    input  wire  logic               clk,
    input  wire  logic               reset,
    output logic                     active,
    output logic [`DATA_W-1:0]       register_v0,

    input  wire  logic               clk_enable,

    output logic [`DATA_W-1:0]       instr_address,
    input  wire  logic [`DATA_W-1:0] instr_readdata,

    output logic [`DATA_W-1:0]       data_address,
    output logic                     data_write,
    output logic                     data_read,
    output logic [`DATA_W-1:0]       data_writedata,
    input  wire  logic [`DATA_W-1:0] data_readdata
);

    logic                    step;
    logic [`REG_ADDR_W-1:0]  rs_addr;
    logic [`REG_ADDR_W-1:0]  rt_addr;
    logic [`REG_ADDR_W-1:0]  wr_addr;
    logic                    wr_en;
    alu_op_t                 alu_op;
    logic                    use_imm;
    logic                    imm_signed;
    logic [`SHAMT_W-1:0]     shamt;
    logic                    shift_var;
    logic [15:0]             imm16;
    logic [25:0]             jump_index;
    branch_kind_t            branch_kind;
    logic                    mem_to_reg;
    logic [`DATA_W-1:0]      rs_data;
    logic [`DATA_W-1:0]      rt_data;
    logic [`DATA_W-1:0]      wr_data;
    logic [`DATA_W-1:0]      imm_ext;
    logic [`DATA_W-1:0]      operand_b;
    logic [`SHAMT_W-1:0]     shift_amount;

    // Operand and write-back steering
    assign imm_ext = imm_signed ? {{(`DATA_W-16){imm16[15]}}, imm16}
                                : {{(`DATA_W-16){1'b0}}, imm16};
    assign operand_b = use_imm ? imm_ext : rt_data;
    assign shift_amount = shift_var ? rs_data[`SHAMT_W-1:0] : shamt;
    assign wr_data = mem_to_reg ? data_readdata : data_address;
    assign data_writedata = rt_data;

    pc_unit u_pc_unit (
        .clk         (clk),
        .reset       (reset),
        .clk_enable  (clk_enable),
        .branch_kind (branch_kind),
        .imm16       (imm16),
        .jump_index  (jump_index),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .pc          (instr_address),
        .step        (step),
        .active      (active)
    );

    instr_decode u_instr_decode (
        .instr       (instr_readdata),
        .step        (step),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .wr_addr     (wr_addr),
        .wr_en       (wr_en),
        .alu_op      (alu_op),
        .use_imm     (use_imm),
        .imm_signed  (imm_signed),
        .shamt       (shamt),
        .shift_var   (shift_var),
        .imm16       (imm16),
        .jump_index  (jump_index),
        .branch_kind (branch_kind),
        .mem_to_reg  (mem_to_reg),
        .data_write  (data_write),
        .data_read   (data_read)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .wr_addr (wr_addr),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0      (register_v0)
    );

    // Result doubles as the load/store effective address
    alu u_alu (
        .alu_op (alu_op),
        .a      (rs_data),
        .b      (operand_b),
        .shamt  (shift_amount),
        .result (data_address)
    );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    // Period of 4 time units
    initial begin
        clk = 1'b0;
    end

    always begin
        #2 clk = ~clk;
    end

endmodule

`default_nettype wire

//--- verification/mips_tb.sv
`default_nettype none

`include "mips_config.svh"

module mips_tb
    import mips_pkg::*;
();

    localparam int PROG_LEN = 200;
    localparam int DATA_WORDS = 64;
    localparam int TIMEOUT_CYCLES = 4 * PROG_LEN * 2;
    localparam int SEED = 61571;

    // Candidate encodings, six bits each
    localparam logic [41:0] ALU_FUNCTS = {F_ADDU, F_SUBU, F_AND, F_OR, F_XOR, F_SLT, F_SLTU};
    localparam logic [17:0] SHIFT_FUNCTS = {F_SLL, F_SRL, F_SRA};
    localparam logic [17:0] VSHIFT_FUNCTS = {F_SLLV, F_SRLV, F_SRAV};
    localparam logic [41:0] IMM_OPS = {OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI,
                                       OP_LUI};

    logic               clk;
    logic               reset;
    logic               clk_enable;
    logic               active;
    logic [`DATA_W-1:0] register_v0;
    logic [`DATA_W-1:0] instr_address;
    logic [`DATA_W-1:0] instr_readdata;
    logic [`DATA_W-1:0] instr_offset;
    logic [`DATA_W-1:0] data_address;
    logic               data_write;
    logic               data_read;
    logic [`DATA_W-1:0] data_writedata;
    logic [`DATA_W-1:0] data_readdata;

    logic [`DATA_W-1:0] prog [PROG_LEN];
    logic [`DATA_W-1:0] data_ram [DATA_WORDS];
    logic [`DATA_W-1:0] model_mem [DATA_WORDS];
    logic [`DATA_W-1:0] model_reg [`NUM_REGS];
    logic [`DATA_W-1:0] model_pc;
    logic [`DATA_W-1:0] model_target;
    logic               model_redirect;
    logic               model_active;
    integer             seed;
    int                 cycle_count = 0;
    int                 halted_cycles;

    tb_clock_gen u_clock_gen (
        .clk (clk)
    );

    mips_cpu_harvard DUT (
        .clk            (clk),
        .reset          (reset),
        .active         (active),
        .register_v0    (register_v0),
        .clk_enable     (clk_enable),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    // Program ROM at the reset vector, nops anywhere else
    assign instr_offset = (instr_address - `RESET_VECTOR) >> 2;
    assign instr_readdata = (instr_offset < PROG_LEN) ? prog[instr_offset] : '0;
    assign data_readdata = data_ram[data_address[7:2]];

    always @(posedge clk) begin
        if (data_write) begin
            data_ram[data_address[7:2]] <= data_writedata;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout: core still running after %0d cycles", cycle_count));
        end
    end

    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] encode_r(input logic [4:0] rs, input logic [4:0] rt,
                                             input logic [4:0] rd, input logic [4:0] sh,
                                             input logic [5:0] fn);
        return {6'b000000, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] fill_word(input int addr);
        return (addr * 32'h0104_0C0D) ^ 32'hC3A5_5A3C;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic build_program();
        int unsigned kind;
        int unsigned span;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dest;
        logic [15:0] imm;
        logic [15:0] mem_off;
        logic        prev_branch;
        prev_branch = 1'b0;
        for (int i = 0; i < PROG_LEN - 2; i++) begin
            rs = pick(32);
            rt = pick(32);
            dest = (pick(4) == 0) ? 5'(`REG_V0) : 5'(pick(32));
            imm = pick(65536);
            mem_off = pick(DATA_WORDS) * 4;
            kind = pick(10);
            // No branch in a delay slot, nor right before the final JR
            if (prev_branch || i > PROG_LEN - 4) begin
                kind = pick(8);
            end
            span = PROG_LEN - 3 - i;
            if (span > 8) begin
                span = 8;
            end
            case (kind)
                0, 1: prog[i] = encode_r(rs, rt, dest, 5'd0, ALU_FUNCTS[6*pick(7) +: 6]);
                2: prog[i] = encode_r(5'd0, rt, dest, 5'(pick(32)), SHIFT_FUNCTS[6*pick(3) +: 6]);
                3: prog[i] = encode_r(rs, rt, dest, 5'd0, VSHIFT_FUNCTS[6*pick(3) +: 6]);
                4, 5: prog[i] = encode_i(IMM_OPS[6*pick(7) +: 6], rs, dest, imm);
                6: prog[i] = encode_i(OP_LW, 5'd0, dest, mem_off);
                7: prog[i] = encode_i(OP_SW, 5'd0, rt, mem_off);
                default: begin
                    // Forward only, so every path reaches the end
                    imm = 16'(1 + pick(span));
                    case (pick(7))
                        0: prog[i] = encode_i(OP_BEQ, rs, rt, imm);
                        1: prog[i] = encode_i(OP_BNE, rs, rt, imm);
                        2: prog[i] = encode_i(OP_BLEZ, rs, 5'd0, imm);
                        3: prog[i] = encode_i(OP_BGTZ, rs, 5'd0, imm);
                        4: prog[i] = encode_i(OP_REGIMM, rs, 5'd0, imm);
                        5: prog[i] = encode_i(OP_REGIMM, rs, 5'd1, imm);
                        default: prog[i] = {OP_J, 26'((`RESET_VECTOR >> 2) + i + 1 + imm)};
                    endcase
                end
            endcase
            prev_branch = (kind >= 8);
        end
        // Back to the halt address through r0, nop in the delay slot
        prog[PROG_LEN-2] = encode_r(5'd0, 5'd0, 5'd0, 5'd0, F_JR);
        prog[PROG_LEN-1] = '0;
    endtask

    task automatic execute_model();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_s;
        logic [31:0] imm_z;
        logic [31:0] pc4;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] tgt;
        logic [4:0]  dest;
        logic [5:0]  op;
        logic        wr;
        logic        taken;
        logic        is_lw;
        logic        is_sw;
        ins = prog[(model_pc - `RESET_VECTOR) >> 2];
        op = ins[31:26];
        a = model_reg[ins[25:21]];
        b = model_reg[ins[20:16]];
        imm_s = {{16{ins[15]}}, ins[15:0]};
        imm_z = {16'h0000, ins[15:0]};
        pc4 = model_pc + 4;
        addr = a + imm_s;
        tgt = pc4 + (imm_s << 2);
        res = '0;
        dest = ins[20:16];
        wr = 1'b0;
        taken = 1'b0;
        is_lw = 1'b0;
        is_sw = 1'b0;
        case (op)
            OP_SPECIAL: begin
                dest = ins[15:11];
                wr = 1'b1;
                case (ins[5:0])
                    F_ADDU: res = a + b;
                    F_SUBU: res = a - b;
                    F_AND:  res = a & b;
                    F_OR:   res = a | b;
                    F_XOR:  res = a ^ b;
                    F_SLT:  res = ($signed(a) < $signed(b));
                    F_SLTU: res = (a < b);
                    F_SLL:  res = b << ins[10:6];
                    F_SRL:  res = b >> ins[10:6];
                    F_SRA:  res = $signed(b) >>> ins[10:6];
                    F_SLLV: res = b << a[4:0];
                    F_SRLV: res = b >> a[4:0];
                    F_SRAV: res = $signed(b) >>> a[4:0];
                    F_JR: begin
                        wr = 1'b0;
                        taken = 1'b1;
                        tgt = a;
                    end
                    default: wr = 1'b0;
                endcase
            end
            OP_REGIMM: taken = (ins[20:16] == 0) ? a[31] : ((ins[20:16] == 1) && !a[31]);
            OP_J: begin
                taken = 1'b1;
                tgt = {pc4[31:28], ins[25:0], 2'b00};
            end
            OP_BEQ:  taken = (a == b);
            OP_BNE:  taken = (a != b);
            OP_BLEZ: taken = ($signed(a) <= 0);
            OP_BGTZ: taken = ($signed(a) > 0);
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                wr = 1'b1;
                case (op)
                    OP_ADDIU: res = a + imm_s;
                    OP_SLTI:  res = ($signed(a) < $signed(imm_s));
                    OP_SLTIU: res = (a < imm_s);
                    OP_ANDI:  res = a & imm_z;
                    OP_ORI:   res = a | imm_z;
                    OP_XORI:  res = a ^ imm_z;
                    default:  res = {ins[15:0], 16'h0000};
                endcase
            end
            OP_LW: begin
                wr = 1'b1;
                is_lw = 1'b1;
                res = model_mem[addr[7:2]];
            end
            OP_SW: begin
                is_sw = 1'b1;
                model_mem[addr[7:2]] = b;
            end
            default: wr = 1'b0;
        endcase
        check_value("data_write", data_write, is_sw);
        check_value("data_read", data_read, is_lw);
        if (is_lw || is_sw) begin
            check_value("data_address", data_address, addr);
        end
        if (is_sw) begin
            check_value("data_writedata", data_writedata, b);
        end
        if (wr && dest != 0) begin
            model_reg[dest] = res;
        end
        model_pc = model_redirect ? model_target : pc4;
        model_redirect = taken;
        if (taken) begin
            model_target = tgt;
        end
    endtask

    // Called 1 unit after a rising edge; checks well before the next one
    task automatic run_cycle();
        clk_enable = (pick(4) != 0);
        #2;
        check_value("active", active, model_active);
        check_value("instr_address", instr_address, model_pc);
        check_value("register_v0", register_v0, model_reg[`REG_V0]);
        if (model_active && clk_enable && model_pc != `HALT_ADDR) begin
            execute_model();
        end else begin
            check_value("data_write", data_write, 1'b0);
            check_value("data_read", data_read, 1'b0);
            if (clk_enable) begin
                model_active = 1'b0;
            end
        end
        if (!model_active) begin
            halted_cycles++;
        end
    endtask

    initial begin
        int i;
        seed = SEED;
        reset = 1'b1;
        clk_enable = 1'b0;
        build_program();
        for (i = 0; i < DATA_WORDS; i++) begin
            data_ram[i] = fill_word(i * 4);
            model_mem[i] = fill_word(i * 4);
        end
        for (i = 0; i < `NUM_REGS; i++) begin
            model_reg[i] = '0;
        end
        model_pc = `RESET_VECTOR;
        model_target = '0;
        model_redirect = 1'b0;
        model_active = 1'b1;
        halted_cycles = 0;

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        run_cycle();
        // Keep going a while after the halt to see active stay low
        while (halted_cycles < 8) begin
            @(posedge clk);
            #1;
            run_cycle();
        end

        for (i = 0; i < DATA_WORDS; i++) begin
            check_value($sformatf("data_ram[%0d]", i), data_ram[i], model_mem[i]);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+verilog
verilog/mips_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/instr_decode.sv
verilog/pc_unit.sv
verilog/mips_cpu_harvard.sv
verification/tb_clock_gen.sv
verification/mips_tb.sv
